/* common/id_defines.svh */
`ifndef ID_DEFINES_SVH
`define ID_DEFINES_SVH

// Data path width of the RV64 core
`define ID_XLEN 64

// Fixed instruction width, no compressed encodings
`define ID_ILEN 32

// Register address, top bit picks the FP bank
`define ID_REG_AW 6

// Integer registers 0-31 and FP registers 32-63
`define ID_NREGS 64

`endif

/* common/id_pkg.sv */
`default_nettype none

`include "id_defines.svh"

package id_pkg;

    // Major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        OP_LOAD      = 7'b0000011,
        OP_LOAD_FP   = 7'b0000111,
        OP_OP_IMM    = 7'b0010011,
        OP_AUIPC     = 7'b0010111,
        OP_OP_IMM_32 = 7'b0011011,
        OP_STORE     = 7'b0100011,
        OP_STORE_FP  = 7'b0100111,
        OP_OP        = 7'b0110011,
        OP_LUI       = 7'b0110111,
        OP_OP_32     = 7'b0111011,
        OP_OP_FP     = 7'b1010011,
        OP_BRANCH    = 7'b1100011,
        OP_JALR      = 7'b1100111,
        OP_JAL       = 7'b1101111
    } opcode_e;

    // ALU control field, func defers to funct3
    typedef enum logic [1:0] {
        ALU_ADD  = 2'b00,
        ALU_SUB  = 2'b01,
        ALU_FUNC = 2'b10,
        ALU_PASS = 2'b11
    } alu_op_e;

    typedef enum logic [4:0] {
        FPU_FADD        = 5'd0,
        FPU_FSUB        = 5'd1,
        FPU_FMUL        = 5'd2,
        FPU_FDIV        = 5'd3,
        FPU_FSGNJ       = 5'd4,
        FPU_FMINMAX     = 5'd5,
        FPU_FCVT_TO_INT = 5'd6,
        FPU_FCVT_TO_FP  = 5'd7,
        FPU_FMV_TO_INT  = 5'd8,
        FPU_FMV_TO_FP   = 5'd9,
        FPU_FCMP        = 5'd10,
        FPU_NONE        = 5'd31
    } fpu_op_e;

    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_BEQ  = 3'd1,
        BR_BNE  = 3'd2,
        BR_BLT  = 3'd3,
        BR_BGE  = 3'd4,
        BR_BLTU = 3'd5,
        BR_BGEU = 3'd6
    } branch_src_e;

    typedef struct packed {
        logic reg_write;
        logic mem_write;
        logic mem_read;
        logic mem_to_reg;
        logic jump;
        logic jalr;
        logic u_src;
        logic uj_src;
        logic alu_src;
        logic alu_fpu;
        logic fpu_rs1;
        logic fpu_rd;
    } ctrl_t;

    typedef struct packed {
        alu_op_e    op;
        logic [2:0] sel;
    } alu_ctrl_t;

    typedef struct packed {
        logic                    valid;
        logic [`ID_REG_AW-1:0]   rd;
        logic [`ID_XLEN-1:0]     data;
    } wb_t;

    // Forwarded rs1 values for the JALR base
    typedef struct packed {
        logic                sel_id_ex;
        logic                sel_ex_mem;
        logic                sel_mem_wb;
        logic [`ID_XLEN-1:0] id_ex_val;
        logic [`ID_XLEN-1:0] ex_mem_val;
        logic [`ID_XLEN-1:0] mem_wb_val;
    } jalr_fwd_t;

endpackage

`default_nettype wire

/* id_stage/decode_control.sv */
`include "id_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module decode_control (
    input  logic [`ID_ILEN-1:0] instr,
    output id_pkg::ctrl_t       ctrl,
    output id_pkg::alu_ctrl_t   alu_ctrl,
    output id_pkg::fpu_op_e     fpu_op,
    output id_pkg::branch_src_e branch_src
);
    import id_pkg::*;

    opcode_e    opcode;
    logic [2:0] funct3;
    logic [4:0] funct5;

    fpu_op_e    fp_op;
    logic       fp_rs1;
    logic       fp_rd;

    assign opcode = opcode_e'(instr[6:0]);
    assign funct3 = instr[14:12];
    // Precision bits of funct7 do not change the operation
    assign funct5 = instr[31:27];

    always_comb begin
        case (funct5)
            5'b00000: fp_op = FPU_FADD;
            5'b00001: fp_op = FPU_FSUB;
            5'b00010: fp_op = FPU_FMUL;
            5'b00011: fp_op = FPU_FDIV;
            5'b00100: fp_op = FPU_FSGNJ;
            5'b00101: fp_op = FPU_FMINMAX;
            5'b10100: fp_op = FPU_FCMP;
            5'b11000: fp_op = FPU_FCVT_TO_INT;
            5'b11010: fp_op = FPU_FCVT_TO_FP;
            5'b11100: fp_op = FPU_FMV_TO_INT;
            5'b11110: fp_op = FPU_FMV_TO_FP;
            default:  fp_op = FPU_NONE;
        endcase
    end

    // Moves and compares to int write x-regs, conversions from int read x-regs
    assign fp_rd  = !(fp_op inside {FPU_FCVT_TO_INT, FPU_FMV_TO_INT, FPU_FCMP});
    assign fp_rs1 = !(fp_op inside {FPU_FCVT_TO_FP, FPU_FMV_TO_FP});

    always_comb begin
        ctrl         = '0;
        alu_ctrl.op  = ALU_ADD;
        alu_ctrl.sel = funct3;
        fpu_op       = FPU_NONE;
        branch_src   = BR_NONE;
        case (opcode)
            OP_LOAD: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
            end
            OP_LOAD_FP: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_fpu    = 1'b1;
                ctrl.fpu_rd     = 1'b1;
            end
            OP_STORE: ctrl.mem_write = 1'b1;
            // Base stays integer, data comes from the FP bank
            OP_STORE_FP: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_fpu   = 1'b1;
            end
            // alu_src selects rs2 as second operand instead of imm
            OP_OP, OP_OP_32: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                alu_ctrl.op    = ALU_FUNC;
            end
            OP_OP_IMM, OP_OP_IMM_32: begin
                ctrl.reg_write = 1'b1;
                alu_ctrl.op    = ALU_FUNC;
            end
            OP_BRANCH: begin
                ctrl.alu_src = 1'b1;
                alu_ctrl.op  = ALU_SUB;
                case (funct3)
                    3'b000:  branch_src = BR_BEQ;
                    3'b001:  branch_src = BR_BNE;
                    3'b100:  branch_src = BR_BLT;
                    3'b101:  branch_src = BR_BGE;
                    3'b110:  branch_src = BR_BLTU;
                    3'b111:  branch_src = BR_BGEU;
                    default: branch_src = BR_NONE;
                endcase
            end
            // uj_src puts pc on the first ALU operand for the link value
            OP_JAL: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.uj_src    = 1'b1;
            end
            OP_JALR: begin
                ctrl.reg_write = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.jalr      = 1'b1;
                ctrl.uj_src    = 1'b1;
            end
            OP_LUI: begin
                ctrl.reg_write = 1'b1;
                ctrl.u_src     = 1'b1;
            end
            OP_AUIPC: begin
                ctrl.reg_write = 1'b1;
                ctrl.u_src     = 1'b1;
                ctrl.uj_src    = 1'b1;
            end
            // ALU only passes operands through, the FPU does the work
            OP_OP_FP: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
                ctrl.alu_fpu   = 1'b1;
                ctrl.fpu_rs1   = fp_rs1;
                ctrl.fpu_rd    = fp_rd;
                alu_ctrl.op    = ALU_PASS;
                fpu_op         = fp_op;
            end
            default: begin
                ctrl         = '0;
                alu_ctrl.sel = 3'b000;
            end
        endcase
    end

endmodule

`default_nettype wire

/* id_stage/imm_gen.sv */
`include "id_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module imm_gen (
    input  logic [`ID_ILEN-1:0] instr,
    output logic [`ID_XLEN-1:0] imm
);
    import id_pkg::*;

    opcode_e opcode;

    assign opcode = opcode_e'(instr[6:0]);

    always_comb begin
        case (opcode)
            OP_LOAD, OP_LOAD_FP, OP_OP_IMM, OP_OP_IMM_32, OP_JALR:
                imm = {{(`ID_XLEN-12){instr[31]}}, instr[31:20]};
            OP_STORE, OP_STORE_FP:
                imm = {{(`ID_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
            // Branch offsets are in halfwords
            OP_BRANCH:
                imm = {{(`ID_XLEN-13){instr[31]}}, instr[31], instr[7],
                       instr[30:25], instr[11:8], 1'b0};
            OP_LUI, OP_AUIPC:
                imm = {{(`ID_XLEN-32){instr[31]}}, instr[31:12], 12'b0};
            OP_JAL:
                imm = {{(`ID_XLEN-21){instr[31]}}, instr[31], instr[19:12],
                       instr[20], instr[30:21], 1'b0};
            // R-type and FP ops carry no immediate
            default:
                imm = '0;
        endcase
    end

endmodule

`default_nettype wire

/* id_stage/regfile.sv */
`include "id_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module regfile (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`ID_REG_AW-1:0] rs1,
    input  logic [`ID_REG_AW-1:0] rs2,
    input  id_pkg::wb_t           wb,
    output logic [`ID_XLEN-1:0]   read_data1,
    output logic [`ID_XLEN-1:0]   read_data2
);
    logic [`ID_XLEN-1:0] regs [`ID_NREGS];

    // x0 is never written, f0 at address 32 is a normal register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `ID_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && (wb.rd != '0)) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Asynchronous reads, no bypass from the write-back port
    assign read_data1 = (rs1 == '0) ? '0 : regs[rs1];
    assign read_data2 = (rs2 == '0) ? '0 : regs[rs2];

endmodule

`default_nettype wire

/* id_stage/branch_unit.sv */
`include "id_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module branch_unit (
    input  logic [`ID_XLEN-1:0] read_data1,
    input  logic [`ID_XLEN-1:0] read_data2,
    input  id_pkg::branch_src_e branch_src,
    input  logic                jump,
    input  logic                jalr,
    input  id_pkg::jalr_fwd_t   jalr_fwd,
    input  logic [`ID_XLEN-1:0] pc,
    input  logic [`ID_XLEN-1:0] imm,
    output logic                redirect,
    output logic [`ID_XLEN-1:0] next_imm_pc
);
    import id_pkg::*;

    logic                eq;
    logic                lt;
    logic                ltu;
    logic                taken;
    logic [`ID_XLEN-1:0] jalr_base;

    assign eq  = (read_data1 == read_data2);
    assign lt  = ($signed(read_data1) < $signed(read_data2));
    assign ltu = (read_data1 < read_data2);

    always_comb begin
        case (branch_src)
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = !eq;
            BR_BLT:  taken = lt;
            BR_BGE:  taken = !lt;
            BR_BLTU: taken = ltu;
            BR_BGEU: taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

    assign redirect = taken | jump;

    // Youngest in-flight producer wins
    always_comb begin
        if (jalr_fwd.sel_id_ex) begin
            jalr_base = jalr_fwd.id_ex_val;
        end else if (jalr_fwd.sel_ex_mem) begin
            jalr_base = jalr_fwd.ex_mem_val;
        end else if (jalr_fwd.sel_mem_wb) begin
            jalr_base = jalr_fwd.mem_wb_val;
        end else begin
            jalr_base = read_data1;
        end
    end

    // Bit 0 is kept as is, the fetch side handles alignment
    assign next_imm_pc = (jalr ? jalr_base : pc) + imm;

endmodule

`default_nettype wire

/* id_stage/id_stage.sv */
`include "id_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module id_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [`ID_XLEN-1:0]   pc,
    input  logic [`ID_ILEN-1:0]   instr,
    input  id_pkg::wb_t           wb,
    input  id_pkg::jalr_fwd_t     jalr_fwd,
    output id_pkg::ctrl_t         ctrl,
    output id_pkg::alu_ctrl_t     alu_ctrl,
    output id_pkg::fpu_op_e       fpu_op,
    output id_pkg::branch_src_e   branch_src,
    output logic [`ID_XLEN-1:0]   read_data1,
    output logic [`ID_XLEN-1:0]   read_data2,
    output logic [`ID_REG_AW-1:0] rs1,
    output logic [`ID_REG_AW-1:0] rs2,
    output logic [`ID_REG_AW-1:0] rd,
    output logic [`ID_XLEN-1:0]   imm,
    output logic                  redirect,
    output logic [`ID_XLEN-1:0]   next_imm_pc
);
    decode_control u_decode_control (
        .instr      (instr),
        .ctrl       (ctrl),
        .alu_ctrl   (alu_ctrl),
        .fpu_op     (fpu_op),
        .branch_src (branch_src)
    );

    // Top address bit selects the FP half of the register file
    // rs2 of an FP instruction is always an FP register
    assign rs1 = {ctrl.alu_fpu & ctrl.fpu_rs1, instr[19:15]};
    assign rs2 = {ctrl.alu_fpu, instr[24:20]};
    assign rd  = {ctrl.alu_fpu & ctrl.fpu_rd, instr[11:7]};

    regfile u_regfile (
        .clk        (clk),
        .rst_n      (rst_n),
        .rs1        (rs1),
        .rs2        (rs2),
        .wb         (wb),
        .read_data1 (read_data1),
        .read_data2 (read_data2)
    );

    imm_gen u_imm_gen (
        .instr (instr),
        .imm   (imm)
    );

    branch_unit u_branch_unit (
        .read_data1  (read_data1),
        .read_data2  (read_data2),
        .branch_src  (branch_src),
        .jump        (ctrl.jump),
        .jalr        (ctrl.jalr),
        .jalr_fwd    (jalr_fwd),
        .pc          (pc),
        .imm         (imm),
        .redirect    (redirect),
        .next_imm_pc (next_imm_pc)
    );

endmodule

`default_nettype wire

/* test/id_stage_chk.sv */
`include "id_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module id_stage_chk (
    input  logic                  clk,
    input  logic                  rst_n,
    input  id_pkg::ctrl_t         ctrl,
    input  logic [`ID_REG_AW-1:0] rs1,
    input  logic [`ID_XLEN-1:0]   read_data1,
    input  logic                  redirect
);
    // Read by the testbench top for the final count
    int unsigned fails = 0;

    a_mem_excl: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctrl.mem_read && ctrl.mem_write))
    else begin
        fails++;
        $error("mem_read and mem_write are both set");
    end

    a_load_path: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.mem_to_reg |-> ctrl.mem_read)
    else begin
        fails++;
        $error("mem_to_reg is set without mem_read");
    end

    a_x0_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rs1 == '0) |-> (read_data1 == '0))
    else begin
        fails++;
        $error("read_data1 is not zero for register 0");
    end

    // No redirect may leave the stage during reset
    a_reset_quiet: assert property (@(posedge clk) !rst_n |-> !redirect)
    else begin
        fails++;
        $error("redirect is high while rst_n is low");
    end

endmodule

`default_nettype wire

/* test/id_stage_monitor.sv */
`include "id_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module id_stage_monitor (
    input  logic                  clk,
    input  logic                  check,
    input  logic                  done_req,
    output logic                  done_ack,
    output int                    checks,
    output int                    errors,
    input  id_pkg::ctrl_t         exp_ctrl,
    input  id_pkg::ctrl_t         act_ctrl,
    input  id_pkg::alu_ctrl_t     exp_alu_ctrl,
    input  id_pkg::alu_ctrl_t     act_alu_ctrl,
    input  id_pkg::fpu_op_e       exp_fpu_op,
    input  id_pkg::fpu_op_e       act_fpu_op,
    input  id_pkg::branch_src_e   exp_branch_src,
    input  id_pkg::branch_src_e   act_branch_src,
    input  logic [`ID_REG_AW-1:0] exp_rs1,
    input  logic [`ID_REG_AW-1:0] act_rs1,
    input  logic [`ID_REG_AW-1:0] exp_rs2,
    input  logic [`ID_REG_AW-1:0] act_rs2,
    input  logic [`ID_REG_AW-1:0] exp_rd,
    input  logic [`ID_REG_AW-1:0] act_rd,
    input  logic [`ID_XLEN-1:0]   exp_imm,
    input  logic [`ID_XLEN-1:0]   act_imm,
    input  logic [`ID_XLEN-1:0]   exp_read_data1,
    input  logic [`ID_XLEN-1:0]   act_read_data1,
    input  logic [`ID_XLEN-1:0]   exp_read_data2,
    input  logic [`ID_XLEN-1:0]   act_read_data2,
    input  logic                  exp_redirect,
    input  logic                  act_redirect,
    input  logic [`ID_XLEN-1:0]   exp_next_imm_pc,
    input  logic [`ID_XLEN-1:0]   act_next_imm_pc
);
    task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            errors++;
            $display("mismatch at %0t ns: %s expected %h actual %h", $time, name, exp, act);
        end
    endtask

    initial begin
        done_ack = 1'b0;
        checks = 0;
        errors = 0;
    end

    // Mid-cycle sample, long after the drive at 2 ns
    always @(negedge clk) begin
        if (check) begin
            checks++;
            compare("ctrl", exp_ctrl, act_ctrl);
            compare("alu_ctrl", exp_alu_ctrl, act_alu_ctrl);
            compare("fpu_op", exp_fpu_op, act_fpu_op);
            compare("branch_src", exp_branch_src, act_branch_src);
            compare("rs1", exp_rs1, act_rs1);
            compare("rs2", exp_rs2, act_rs2);
            compare("rd", exp_rd, act_rd);
            compare("imm", exp_imm, act_imm);
            compare("read_data1", exp_read_data1, act_read_data1);
            compare("read_data2", exp_read_data2, act_read_data2);
            compare("redirect", exp_redirect, act_redirect);
            compare("next_imm_pc", exp_next_imm_pc, act_next_imm_pc);
        end
        if (done_req) begin
            done_ack = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* test/id_stage_tb.sv */
`include "id_defines.svh"

`timescale 1ns/1ps
`default_nettype none

module id_stage_tb;
    import id_pkg::*;

    // Bit order is reg_write mem_write mem_read mem_to_reg
    // then jump jalr u_src uj_src alu_src alu_fpu fpu_rs1 fpu_rd
    localparam logic [11:0] C_OP    = 12'b1000_0000_1000;
    localparam logic [11:0] C_OPI   = 12'b1000_0000_0000;
    localparam logic [11:0] C_LD    = 12'b1011_0000_0000;
    localparam logic [11:0] C_LDF   = 12'b1011_0000_0101;
    localparam logic [11:0] C_ST    = 12'b0100_0000_0000;
    localparam logic [11:0] C_STF   = 12'b0100_0000_0100;
    localparam logic [11:0] C_BR    = 12'b0000_0000_1000;
    localparam logic [11:0] C_JAL   = 12'b1000_1001_0000;
    localparam logic [11:0] C_JALR  = 12'b1000_1101_0000;
    localparam logic [11:0] C_LUI   = 12'b1000_0010_0000;
    localparam logic [11:0] C_AUIPC = 12'b1000_0011_0000;
    localparam logic [11:0] C_FADD  = 12'b1000_0000_1111;
    localparam logic [11:0] C_FMVX  = 12'b1000_0000_1110;
    localparam logic [11:0] C_FCVT  = 12'b1000_0000_1101;
    localparam logic [31:0] NOP     = 32'h0000_0013;

    typedef struct packed {
        wb_t                 wb;
        logic [31:0]         instr;
        logic [63:0]         pc;
        jalr_fwd_t           fwd;
        ctrl_t               ctrl;
        alu_ctrl_t           alu;
        fpu_op_e             fpu;
        branch_src_e         br;
        logic [5:0]          rs1;
        logic [5:0]          rs2;
        logic [5:0]          rd;
        logic [63:0]         imm;
        logic                redirect;
        logic [63:0]         nip;
        logic [63:0]         rd1;
        logic [63:0]         rd2;
    } entry_t;

    logic clk;
    logic rst_n;
    logic check;
    logic done_req;
    logic done_ack;
    int   mon_checks;
    int   mon_errors;

    entry_t              cur;
    entry_t              table_q[$];
    logic [`ID_XLEN-1:0] model [`ID_NREGS];
    logic [31:0]         lcg_state;
    wb_t                 nxt_wb;
    jalr_fwd_t           nxt_fwd;
    logic [63:0]         nxt_pc;
    logic [63:0]         fwd_val [3];

    ctrl_t                 ctrl;
    alu_ctrl_t             alu_ctrl;
    fpu_op_e               fpu_op;
    branch_src_e           branch_src;
    logic [`ID_XLEN-1:0]   read_data1;
    logic [`ID_XLEN-1:0]   read_data2;
    logic [`ID_REG_AW-1:0] rs1;
    logic [`ID_REG_AW-1:0] rs2;
    logic [`ID_REG_AW-1:0] rd;
    logic [`ID_XLEN-1:0]   imm;
    logic                  redirect;
    logic [`ID_XLEN-1:0]   next_imm_pc;

    id_stage dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .pc          (cur.pc),
        .instr       (cur.instr),
        .wb          (cur.wb),
        .jalr_fwd    (cur.fwd),
        .ctrl        (ctrl),
        .alu_ctrl    (alu_ctrl),
        .fpu_op      (fpu_op),
        .branch_src  (branch_src),
        .read_data1  (read_data1),
        .read_data2  (read_data2),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .redirect    (redirect),
        .next_imm_pc (next_imm_pc)
    );

    bind id_stage id_stage_chk u_chk (
        .clk        (clk),
        .rst_n      (rst_n),
        .ctrl       (ctrl),
        .rs1        (rs1),
        .read_data1 (read_data1),
        .redirect   (redirect)
    );

    id_stage_monitor u_monitor (
        .clk             (clk),
        .check           (check),
        .done_req        (done_req),
        .done_ack        (done_ack),
        .checks          (mon_checks),
        .errors          (mon_errors),
        .exp_ctrl        (cur.ctrl),
        .act_ctrl        (ctrl),
        .exp_alu_ctrl    (cur.alu),
        .act_alu_ctrl    (alu_ctrl),
        .exp_fpu_op      (cur.fpu),
        .act_fpu_op      (fpu_op),
        .exp_branch_src  (cur.br),
        .act_branch_src  (branch_src),
        .exp_rs1         (cur.rs1),
        .act_rs1         (rs1),
        .exp_rs2         (cur.rs2),
        .act_rs2         (rs2),
        .exp_rd          (cur.rd),
        .act_rd          (rd),
        .exp_imm         (cur.imm),
        .act_imm         (imm),
        .exp_read_data1  (cur.rd1),
        .act_read_data1  (read_data1),
        .exp_read_data2  (cur.rd2),
        .act_read_data2  (read_data2),
        .exp_redirect    (cur.redirect),
        .act_redirect    (redirect),
        .exp_next_imm_pc (cur.nip),
        .act_next_imm_pc (next_imm_pc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [63:0] rand64();
        logic [31:0] hi;
        hi = lcg_next();
        return {hi, lcg_next()};
    endfunction

    // Instruction encoders taking the immediate as a plain value
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd, input logic [6:0] opc);
        return {f7, rs2, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] i_type(input longint v, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {v[11:0], rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input longint v, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [6:0] opc);
        return {v[11:5], rs2, rs1, f3, v[4:0], opc};
    endfunction

    function automatic logic [31:0] b_type(input longint v, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {v[12], v[10:5], rs2, rs1, f3, v[4:1], v[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] u_type(input longint v, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {v[31:12], rd, opc};
    endfunction

    function automatic logic [31:0] j_type(input longint v, input logic [4:0] rd);
        return {v[20], v[10:1], v[11], v[19:12], rd, OP_JAL};
    endfunction

    function automatic logic branch_taken(input branch_src_e br, input logic [63:0] v1,
                                          input logic [63:0] v2);
        case (br)
            BR_BEQ:  return v1 == v2;
            BR_BNE:  return v1 != v2;
            BR_BLT:  return $signed(v1) < $signed(v2);
            BR_BGE:  return $signed(v1) >= $signed(v2);
            BR_BLTU: return v1 < v2;
            BR_BGEU: return v1 >= v2;
            default: return 1'b0;
        endcase
    endfunction

    task automatic stage_write(input logic [5:0] addr, input logic [63:0] data);
        nxt_wb.valid = 1'b1;
        nxt_wb.rd    = addr;
        nxt_wb.data  = data;
    endtask

    task automatic select_fwd(input logic [2:0] sel);
        nxt_fwd.sel_id_ex  = sel[2];
        nxt_fwd.sel_ex_mem = sel[1];
        nxt_fwd.sel_mem_wb = sel[0];
        nxt_fwd.id_ex_val  = fwd_val[0];
        nxt_fwd.ex_mem_val = fwd_val[1];
        nxt_fwd.mem_wb_val = fwd_val[2];
    endtask

    // Expected results come from the register model before this entry's write
    task automatic add_entry(input logic [31:0] instr, input logic [11:0] c, input alu_op_e op,
                             input fpu_op_e f, input branch_src_e br, input longint v);
        entry_t      e;
        logic [63:0] base;
        e          = '0;
        e.instr    = instr;
        e.pc       = nxt_pc;
        e.wb       = nxt_wb;
        e.fwd      = nxt_fwd;
        e.ctrl     = ctrl_t'(c);
        e.alu.op   = op;
        e.alu.sel  = instr[14:12];
        e.fpu      = f;
        e.br       = br;
        e.rs1      = {e.ctrl.alu_fpu & e.ctrl.fpu_rs1, instr[19:15]};
        e.rs2      = {e.ctrl.alu_fpu, instr[24:20]};
        e.rd       = {e.ctrl.alu_fpu & e.ctrl.fpu_rd, instr[11:7]};
        e.rd1      = model[e.rs1];
        e.rd2      = model[e.rs2];
        e.imm      = v;
        e.redirect = e.ctrl.jump | branch_taken(br, e.rd1, e.rd2);
        if (nxt_fwd.sel_id_ex) begin
            base = nxt_fwd.id_ex_val;
        end else if (nxt_fwd.sel_ex_mem) begin
            base = nxt_fwd.ex_mem_val;
        end else if (nxt_fwd.sel_mem_wb) begin
            base = nxt_fwd.mem_wb_val;
        end else begin
            base = e.rd1;
        end
        e.nip = (e.ctrl.jalr ? base : nxt_pc) + e.imm;
        table_q.push_back(e);
        if (nxt_wb.valid && nxt_wb.rd != 6'd0) begin
            model[nxt_wb.rd] = nxt_wb.data;
        end
        nxt_wb  = '0;
        nxt_fwd = '0;
    endtask

    task automatic build_table();
        logic [63:0] a, b, c, d, pos, neg, r;
        for (int i = 0; i < `ID_NREGS; i++) begin
            model[i] = '0;
        end
        nxt_wb  = '0;
        nxt_fwd = '0;
        nxt_pc  = 64'h0000_0000_8000_1000;
        a = rand64();
        b = rand64();
        c = rand64();
        d = rand64();
        r = rand64();
        fwd_val[0] = rand64();
        fwd_val[1] = rand64();
        fwd_val[2] = rand64();
        // Equal magnitude bits with opposite signs
        pos = {1'b0, a[62:0]};
        neg = {1'b1, a[62:0]};
        // Every integer and FP register reads zero straight out of reset
        for (int k = 0; k < 16; k++) begin
            add_entry(r_type(7'd0, 5'(31 - k), 5'(k), 3'd0, 5'd3, OP_OP), C_OP, ALU_FUNC,
                      FPU_NONE, BR_NONE, 0);
            add_entry(r_type(7'b0000001, 5'(31 - k), 5'(k), 3'd0, 5'd2, OP_OP_FP), C_FADD,
                      ALU_PASS, FPU_FADD, BR_NONE, 0);
        end
        // Reset contents, x0 writes, bank 32+ and write-then-read
        stage_write(6'd1, a);
        add_entry(r_type(7'd0, 5'd2, 5'd1, 3'd0, 5'd3, OP_OP), C_OP, ALU_FUNC, FPU_NONE, BR_NONE, 0);
        stage_write(6'd2, b);
        add_entry(NOP, C_OPI, ALU_FUNC, FPU_NONE, BR_NONE, 0);
        stage_write(6'd0, r);
        add_entry(r_type(7'd0, 5'd2, 5'd1, 3'd0, 5'd3, OP_OP), C_OP, ALU_FUNC, FPU_NONE, BR_NONE, 0);
        stage_write(6'd12, pos);
        add_entry(r_type(7'd0, 5'd1, 5'd0, 3'd0, 5'd4, OP_OP), C_OP, ALU_FUNC, FPU_NONE, BR_NONE, 0);
        stage_write(6'd13, neg);
        add_entry(i_type(-8, 5'd1, 3'd3, 5'd6, OP_LOAD), C_LD, ALU_ADD, FPU_NONE, BR_NONE, -8);
        stage_write(6'd32, c);
        add_entry(i_type(16, 5'd2, 3'd3, 5'd4, OP_LOAD_FP), C_LDF, ALU_ADD, FPU_NONE, BR_NONE, 16);
        stage_write(6'd33, d);
        add_entry(s_type(-20, 5'd2, 5'd1, 3'd3, OP_STORE), C_ST, ALU_ADD, FPU_NONE, BR_NONE, -20);
        add_entry(s_type(2047, 5'd1, 5'd1, 3'd3, OP_STORE_FP), C_STF, ALU_ADD, FPU_NONE, BR_NONE,
                  2047);
        // fadd.d, fmv.x.d and fcvt.d.l cover the bank select cases
        add_entry(r_type(7'b0000001, 5'd1, 5'd0, 3'd0, 5'd2, OP_OP_FP), C_FADD, ALU_PASS,
                  FPU_FADD, BR_NONE, 0);
        add_entry(r_type(7'b1110001, 5'd0, 5'd0, 3'd0, 5'd5, OP_OP_FP), C_FMVX, ALU_PASS,
                  FPU_FMV_TO_INT, BR_NONE, 0);
        add_entry(r_type(7'b1101001, 5'd2, 5'd1, 3'd0, 5'd3, OP_OP_FP), C_FCVT, ALU_PASS,
                  FPU_FCVT_TO_FP, BR_NONE, 0);
        add_entry(i_type(-2048, 5'd1, 3'd0, 5'd7, OP_OP_IMM), C_OPI, ALU_FUNC, FPU_NONE, BR_NONE,
                  -2048);
        add_entry(i_type(5, 5'd2, 3'd0, 5'd8, OP_OP_IMM_32), C_OPI, ALU_FUNC, FPU_NONE, BR_NONE, 5);
        add_entry(r_type(7'b0100000, 5'd2, 5'd1, 3'd0, 5'd9, OP_OP_32), C_OP, ALU_FUNC, FPU_NONE,
                  BR_NONE, 0);
        add_entry(u_type(64'hffff_ffff_8000_5000, 5'd10, OP_LUI), C_LUI, ALU_ADD, FPU_NONE,
                  BR_NONE, 64'hffff_ffff_8000_5000);
        add_entry(u_type(64'h1234_5000, 5'd11, OP_AUIPC), C_AUIPC, ALU_ADD, FPU_NONE, BR_NONE,
                  64'h1234_5000);
        // Control flow at a random aligned pc
        nxt_pc = {r[63:2], 2'b00};
        add_entry(j_type(-1024, 5'd1), C_JAL, ALU_ADD, FPU_NONE, BR_NONE, -1024);
        add_entry(b_type(64, 5'd1, 5'd1, 3'b000), C_BR, ALU_SUB, FPU_NONE, BR_BEQ, 64);
        add_entry(b_type(-64, 5'd2, 5'd1, 3'b000), C_BR, ALU_SUB, FPU_NONE, BR_BEQ, -64);
        add_entry(b_type(128, 5'd2, 5'd1, 3'b001), C_BR, ALU_SUB, FPU_NONE, BR_BNE, 128);
        add_entry(b_type(-4096, 5'd13, 5'd12, 3'b100), C_BR, ALU_SUB, FPU_NONE, BR_BLT, -4096);
        add_entry(b_type(24, 5'd12, 5'd13, 3'b100), C_BR, ALU_SUB, FPU_NONE, BR_BLT, 24);
        add_entry(b_type(4094, 5'd13, 5'd12, 3'b101), C_BR, ALU_SUB, FPU_NONE, BR_BGE, 4094);
        add_entry(b_type(8, 5'd13, 5'd12, 3'b110), C_BR, ALU_SUB, FPU_NONE, BR_BLTU, 8);
        add_entry(b_type(-8, 5'd13, 5'd12, 3'b111), C_BR, ALU_SUB, FPU_NONE, BR_BGEU, -8);
        add_entry(b_type(-512, 5'd1, 5'd1, 3'b111), C_BR, ALU_SUB, FPU_NONE, BR_BGEU, -512);
        // JALR base from each forwarding source, then all, then none
        select_fwd(3'b100);
        add_entry(i_type(12, 5'd1, 3'd0, 5'd1, OP_JALR), C_JALR, ALU_ADD, FPU_NONE, BR_NONE, 12);
        select_fwd(3'b010);
        add_entry(i_type(12, 5'd1, 3'd0, 5'd1, OP_JALR), C_JALR, ALU_ADD, FPU_NONE, BR_NONE, 12);
        select_fwd(3'b001);
        add_entry(i_type(12, 5'd1, 3'd0, 5'd1, OP_JALR), C_JALR, ALU_ADD, FPU_NONE, BR_NONE, 12);
        select_fwd(3'b111);
        add_entry(i_type(-36, 5'd1, 3'd0, 5'd1, OP_JALR), C_JALR, ALU_ADD, FPU_NONE, BR_NONE, -36);
        select_fwd(3'b000);
        add_entry(i_type(-36, 5'd1, 3'd0, 5'd1, OP_JALR), C_JALR, ALU_ADD, FPU_NONE, BR_NONE, -36);
    endtask

    initial begin
        int timeouts;
        int others;
        int asserts;
        int n;
        timeouts  = 0;
        others    = 0;
        lcg_state = 32'h4ce399d4;
        rst_n     = 1'b0;
        check     = 1'b0;
        done_req  = 1'b0;
        cur       = '0;
        cur.instr = NOP;
        build_table();
        repeat (16) @(posedge clk);
        #2;
        rst_n = 1'b1;
        foreach (table_q[i]) begin
            cur   = table_q[i];
            check = 1'b1;
            @(posedge clk);
            #2;
        end
        check     = 1'b0;
        cur       = '0;
        cur.instr = NOP;
        done_req  = 1'b1;
        for (n = 0; n < 20 && !done_ack; n++) begin
            @(posedge clk);
        end
        if (!done_ack) begin
            $display("timeout: the monitor did not acknowledge the end of the table");
            timeouts++;
        end
        if (mon_checks != table_q.size()) begin
            $display("the monitor checked %0d of %0d table entries", mon_checks, table_q.size());
            others++;
        end
        asserts = dut0.u_chk.fails;
        $display("checks %0d, mismatches %0d, assertion failures %0d, timeouts %0d, other %0d",
                 mon_checks, mon_errors, asserts, timeouts, others);
        if (mon_errors == 0 && asserts == 0 && timeouts == 0 && others == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+common
common/id_pkg.sv
id_stage/decode_control.sv
id_stage/imm_gen.sv
id_stage/regfile.sv
id_stage/branch_unit.sv
id_stage/id_stage.sv
test/id_stage_chk.sv
test/id_stage_monitor.sv
test/id_stage_tb.sv
